// ==== dv/loopback_model.svh ====
`ifndef LOOPBACK_MODEL_SVH
`define LOOPBACK_MODEL_SVH

// Bytes in order of acceptance, which is also the expected output order
narrow_beat_t model_q[$];

task automatic record_input(narrow_beat_t beat);
  model_q.push_back(beat);
endtask

task automatic compare_flag(string what, logic got, logic expected);
  if (got !== expected) begin
    stop_with_failure($sformatf("FAILED at %0t: %s is %b, expected %b",
                                $time, what, got, expected));
  end
endtask

task automatic compare_narrow_beat(string what, narrow_beat_t got, narrow_beat_t expected);
  if (got.data !== expected.data) begin
    stop_with_failure($sformatf("FAILED at %0t: %s data is %02h, expected %02h",
                                $time, what, got.data, expected.data));
  end else if (got.last !== expected.last) begin
    stop_with_failure($sformatf("FAILED at %0t: %s last is %b, expected %b",
                                $time, what, got.last, expected.last));
  end else if (got.user !== expected.user) begin
    stop_with_failure($sformatf("FAILED at %0t: %s user is %b, expected %b",
                                $time, what, got.user, expected.user));
  end
endtask

task automatic check_output(narrow_beat_t got);
  narrow_beat_t expected;
  if (model_q.size() == 0) begin
    stop_with_failure("An output beat appeared with no input byte left to match it");
  end else begin
    expected = model_q.pop_front();
    compare_narrow_beat("output beat", got, expected);
  end
endtask

// A stalled beat must already be the next expected byte
task automatic check_stalled(narrow_beat_t got);
  if (model_q.size() == 0) begin
    stop_with_failure("A stalled output beat appeared with no input byte left to match it");
  end else begin
    compare_narrow_beat("stalled beat", got, model_q[0]);
  end
endtask

`endif

// ==== dv/width_loopback_tb.sv ====
`timescale 1ns/10ps

module width_loopback_tb
  import width_adapt_pkg::*;
;

  localparam int wait_limit  = 2000;  // Cycles per wait loop
  localparam int packet_cnt  = 70;
  localparam int steady_pkts = 30;  // Packets before back-pressure starts

  logic         clk;
  logic         rst;
  narrow_beat_t in_beat;
  logic         in_valid;
  logic         in_ready;
  narrow_beat_t out_beat;
  logic         out_valid;
  logic         out_ready;

  logic [15:0]  lfsr_state;
  logic         ready_random;
  int           stretch;
  logic         stall_prev;

  `include "loopback_model.svh"

  width_loopback_top dut_i (
    .clk(clk), .rst(rst),
    .in_beat(in_beat), .in_valid(in_valid), .in_ready(in_ready),
    .out_beat(out_beat), .out_valid(out_valid), .out_ready(out_ready)
  );

  always #4 clk = ~clk;

  task automatic stop_with_failure(string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1);
  endtask

  function automatic logic [15:0] lfsr_step(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // Galois form of x^16+x^14+x^13+x^11+1
  endfunction

  function automatic int take_bits(int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = (v << 1) | lfsr_state[0];
    end
    return v;
  endfunction

  // Moves to the next falling edge and updates out_ready there
  task automatic advance_cycle();
    @(negedge clk);
    if (!ready_random) begin
      out_ready = 1'b1;
    end else begin
      if (stretch == 0) begin
        if (take_bits(1)) begin
          out_ready = 1'b1;
          stretch   = take_bits(3) + 1;
        end else begin
          out_ready = 1'b0;
          stretch   = take_bits(5) + 1;  // Long stall
        end
      end
      stretch--;
    end
  endtask

  task automatic send_byte(narrow_beat_t beat);
    int   gap;
    int   waited;
    logic taken;
    gap = (take_bits(2) == 0) ? take_bits(2) + 1 : 0;
    in_valid = 1'b0;
    for (int i = 0; i < gap; i++) begin
      advance_cycle();
    end
    in_beat  = beat;
    in_valid = 1'b1;
    waited   = 0;
    taken    = 1'b0;
    while (!taken && waited < wait_limit) begin
      @(posedge clk);
      taken = in_ready;
      advance_cycle();
      waited++;
    end
    if (!taken) begin
      stop_with_failure("Timeout while waiting for the DUT to accept an input byte");
    end
    in_valid = 1'b0;
  endtask

  task automatic send_packet(int len, logic user);
    narrow_beat_t beat;
    for (int i = 0; i < len; i++) begin
      beat.data = lane_width'(take_bits(lane_width));
      beat.last = (i == len - 1);
      beat.user = user && (i == len - 1);  // Error flag rides on the final byte
      send_byte(beat);
    end
  endtask

  always @(posedge clk) begin
    if (!rst) begin
      if (in_valid && in_ready) begin
        record_input(in_beat);
      end
      if (stall_prev) begin
        compare_flag("out_valid while stalled", out_valid, 1'b1);
      end
      stall_prev = out_valid && !out_ready;
      if (out_valid && out_ready) begin
        check_output(out_beat);
      end else if (out_valid) begin
        check_stalled(out_beat);
      end
    end
  end

  initial begin
    int len;
    int waited;
    clk          = 1'b0;
    rst          = 1'b1;
    in_beat      = '0;
    in_valid     = 1'b0;
    out_ready    = 1'b1;
    ready_random = 1'b0;
    stretch      = 0;
    stall_prev   = 1'b0;
    lfsr_state   = 16'd24777;

    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    @(posedge clk);
    compare_flag("out_valid after reset", out_valid, 1'b0);
    compare_flag("in_ready after reset", in_ready, 1'b0);
    waited = 0;
    while (!in_ready && waited < wait_limit) begin
      @(posedge clk);
      waited++;
    end
    if (!in_ready) begin
      stop_with_failure("Timeout while waiting for in_ready to rise after reset");
    end
    advance_cycle();

    for (int pkt = 0; pkt < packet_cnt; pkt++) begin
      if (pkt == steady_pkts) begin
        ready_random = 1'b1;
      end
      case (pkt % 8)
        0:       len = 1;
        1:       len = lane_count;  // Exactly one full wide beat
        2:       len = 2 * lane_count;
        default: len = take_bits(5) % 20 + 1;
      endcase
      send_packet(len, take_bits(1) != 0);
    end

    ready_random = 1'b0;
    waited       = 0;
    while (model_q.size() != 0 && waited < wait_limit) begin
      advance_cycle();
      waited++;
    end
    if (model_q.size() != 0) begin
      stop_with_failure("Timeout while waiting for the output to drain the model queue");
    end
    repeat (30) advance_cycle();  // Any extra output beat fails in the monitor

    $display("No errors");
    $finish;
  end

endmodule

// ==== hdl/adapter_fsm.sv ====
`timescale 1ns/10ps

module adapter_fsm
  import width_adapt_pkg::*;
#(
  parameter bit expand = 1'b1  // 1 packs narrow to wide, 0 unpacks
) (
  input  logic clk,
  input  logic rst,
  input  logic up_valid,
  input  logic up_last,
  output logic up_ready,
  output logic dn_valid,
  input  logic dn_ready_early,
  input  logic lane_last,
  input  logic at_end,
  output logic cnt_load,
  output logic cnt_step,
  output logic cnt_clear,
  output logic capture,
  output logic emit
);

  adapt_state_e state;
  adapt_state_e state_next;
  logic         up_ready_next;
  logic         dn_ready;  // Same register as the skid buffer's in_ready
  logic         up_hs;
  logic         dn_hs;

  assign up_hs    = up_valid & up_ready;
  assign dn_valid = (state == st_emit);
  assign dn_hs    = dn_valid & dn_ready;
  assign capture  = up_hs;
  assign emit     = dn_hs;

  always_comb begin
    state_next    = state;
    up_ready_next = 1'b0;
    cnt_load      = 1'b0;
    cnt_step      = 1'b0;
    cnt_clear     = 1'b0;
    case (state)
      st_idle: begin
        up_ready_next = 1'b1;
        if (up_hs) begin
          if (!expand) begin
            up_ready_next = 1'b0;
            state_next    = st_emit;
          end else if (up_last) begin
            cnt_clear     = 1'b1;  // One byte packet
            up_ready_next = dn_ready_early;
            state_next    = st_emit;
          end else begin
            cnt_step   = 1'b1;
            state_next = st_collect;
          end
        end
      end
      st_collect: begin
        if (!expand) begin
          state_next = st_idle;
        end else begin
          up_ready_next = 1'b1;
          if (up_hs) begin
            if (at_end || up_last) begin
              cnt_clear     = 1'b1;
              up_ready_next = dn_ready_early;
              state_next    = st_emit;
            end else begin
              cnt_step = 1'b1;
            end
          end
        end
      end
      st_emit: begin
        if (expand) begin
          up_ready_next = dn_ready_early;  // Keeps up_ready equal to dn_ready
          if (dn_hs && up_hs) begin
            if (up_last) begin
              cnt_clear = 1'b1;
            end else begin
              cnt_load      = 1'b1;  // New byte went to lane 0
              up_ready_next = 1'b1;
              state_next    = st_collect;
            end
          end else if (dn_hs) begin
            up_ready_next = 1'b1;
            state_next    = st_idle;
          end
        end else begin
          if (dn_hs && lane_last) begin
            cnt_clear = 1'b1;
            if (!up_hs) begin
              up_ready_next = 1'b1;
              state_next    = st_idle;
            end
          end else if (dn_hs) begin
            cnt_step = 1'b1;
          end else begin
            // Final lane waiting; it surely leaves next cycle if ready is on its way
            up_ready_next = dn_ready_early & lane_last;
          end
        end
      end
      default: begin
        state_next = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= st_idle;
      up_ready <= 1'b0;
      dn_ready <= 1'b0;
    end else begin
      state    <= state_next;
      up_ready <= up_ready_next;
      dn_ready <= dn_ready_early;
    end
  end

  // The emit state is left only through a downstream handshake
  emit_held: assert property (@(posedge clk) disable iff (rst)
    state == st_emit && !emit |=> state == st_emit);

  // A held beat is only overwritten as it leaves
  capture_frees: assert property (@(posedge clk) disable iff (rst)
    capture && state == st_emit |-> emit);

endmodule

// ==== hdl/lane_counter.sv ====
`timescale 1ns/10ps

module lane_counter
  import width_adapt_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      load,
  input  logic      step,
  input  logic      clear,
  input  lane_idx_t load_val,
  output lane_idx_t idx,
  output logic      at_end
);

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      idx <= '0;
    end else if (load) begin
      idx <= load_val;
    end else if (step) begin
      idx <= idx + 1'b1;
    end
  end

  assign at_end = (idx == lane_idx_t'(lane_count - 1));  // Top lane

  step_load_excl: assert property (@(posedge clk) disable iff (rst)
    !(step && load));

  // Both halves close a beat by clearing, never by wrapping
  no_wrap: assert property (@(posedge clk) disable iff (rst)
    step |-> !at_end);

endmodule

// ==== hdl/lane_packer.sv ====
`timescale 1ns/10ps

module lane_packer
  import width_adapt_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  narrow_beat_t in_beat,
  input  logic         capture,
  input  lane_idx_t    idx,
  output wide_beat_t   wide
);

  logic [lane_count*lane_width-1:0] data_q;
  logic [lane_count-1:0]            keep_q;
  logic [lane_count-1:0]            lane_bit;
  logic                             last_q;
  logic                             user_q;

  assign lane_bit = lane_count'(1) << idx;

  always_ff @(posedge clk) begin
    if (capture) begin
      data_q[idx*lane_width +: lane_width] <= in_beat.data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      keep_q <= '0;
      last_q <= 1'b0;
      user_q <= 1'b0;
    end else if (capture) begin
      keep_q <= ((idx == '0) ? '0 : keep_q) | lane_bit;  // Lane 0 starts a new beat
      last_q <= in_beat.last;  // Closing byte wins
      user_q <= in_beat.user;
    end
  end

  assign wide = '{data: data_q, keep: keep_q, last: last_q, user: user_q};

  // Lanes fill in order, so the lane below is always written first
  fill_in_order: assert property (@(posedge clk) disable iff (rst)
    capture && idx != '0 |-> keep_q[idx - 1'b1]);

endmodule

// ==== hdl/lane_unpacker.sv ====
`timescale 1ns/10ps

module lane_unpacker
  import width_adapt_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  wide_beat_t   wide,
  input  logic         capture,
  input  lane_idx_t    idx,
  output narrow_beat_t narrow,
  output logic         lane_last
);

  logic [lane_count*lane_width-1:0] data_q;
  logic [lane_count-1:0]            keep_q;
  logic                             last_q;
  logic                             user_q;
  lane_idx_t                        next_idx;

  always_ff @(posedge clk) begin
    if (capture) begin
      data_q <= wide.data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      keep_q <= '0;
      last_q <= 1'b0;
      user_q <= 1'b0;
    end else if (capture) begin
      keep_q <= wide.keep;
      last_q <= wide.last;
      user_q <= wide.user;
    end
  end

  assign next_idx  = idx + 1'b1;
  assign lane_last = (idx == lane_idx_t'(lane_count - 1)) || !keep_q[next_idx];

  // Flags only ride on the final byte of the beat
  assign narrow = '{
    data: data_q[idx*lane_width +: lane_width],
    last: last_q & lane_last,
    user: user_q & lane_last
  };

  keep_contig: assert property (@(posedge clk) disable iff (rst)
    capture |=> keep_q[0] && ((keep_q & (keep_q + 1'b1)) == '0));

endmodule

// ==== hdl/skid_buffer.sv ====
`timescale 1ns/10ps

module skid_buffer #(
  parameter int width = 8
) (
  input  logic             clk,
  input  logic             rst,
  input  logic [width-1:0] in_data,
  input  logic             in_valid,
  output logic             in_ready,
  output logic             in_ready_early,
  output logic [width-1:0] out_data,
  output logic             out_valid,
  input  logic             out_ready
);

  logic [width-1:0] main_data;
  logic [width-1:0] temp_data;
  logic             temp_valid;

  // Ready next cycle if the sink drains or one entry is guaranteed free
  assign in_ready_early = out_ready | (~temp_valid & ~out_valid) | (~temp_valid & ~in_valid);

  assign out_data = main_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      in_ready   <= 1'b0;
      out_valid  <= 1'b0;
      temp_valid <= 1'b0;
    end else begin
      in_ready <= in_ready_early;
      if (in_ready) begin
        if (out_ready || !out_valid) begin
          out_valid <= in_valid;
        end else begin
          temp_valid <= in_valid;  // Sink stalled, park in temp
        end
      end else if (out_ready) begin
        out_valid  <= temp_valid;
        temp_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_ready) begin
      if (out_ready || !out_valid) begin
        main_data <= in_data;
      end else begin
        temp_data <= in_data;
      end
    end else if (out_ready) begin
      main_data <= temp_data;
    end
  end

  hold_stable: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

// ==== hdl/width_adapt_pkg.sv ====
package width_adapt_pkg;

  localparam int lane_count = 8;  // Byte lanes per wide beat
  localparam int lane_width = 8;

  typedef logic [2:0] lane_idx_t;

  typedef struct packed {
    logic [lane_width-1:0] data;
    logic                  last;
    logic                  user;  // Packet error flag
  } narrow_beat_t;

  typedef struct packed {
    logic [lane_count*lane_width-1:0] data;
    logic [lane_count-1:0]            keep;  // Contiguous from lane 0
    logic                             last;
    logic                             user;
  } wide_beat_t;

  typedef enum logic [1:0] {
    st_idle    = 2'd0,
    st_collect = 2'd1,  // Pack direction only
    st_emit    = 2'd2
  } adapt_state_e;

endpackage

// ==== hdl/width_loopback_top.sv ====
`timescale 1ns/10ps

module width_loopback_top
  import width_adapt_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  narrow_beat_t in_beat,
  input  logic         in_valid,
  output logic         in_ready,
  output narrow_beat_t out_beat,
  output logic         out_valid,
  input  logic         out_ready
);

  lane_idx_t    pk_idx;
  logic         pk_at_end;
  logic         pk_load;
  logic         pk_step;
  logic         pk_clear;
  logic         pk_capture;
  logic         pk_valid;
  logic         pk_ready_early;
  wide_beat_t   pk_wide;
  wide_beat_t   mid_wide;
  logic         mid_valid;
  logic         mid_ready;
  lane_idx_t    un_idx;
  logic         un_at_end;
  logic         un_load;
  logic         un_step;
  logic         un_clear;
  logic         un_capture;
  logic         un_valid;
  logic         un_ready_early;
  logic         un_lane_last;
  narrow_beat_t un_narrow;

  adapter_fsm #(.expand(1'b1)) pack_fsm (
    .clk(clk), .rst(rst),
    .up_valid(in_valid), .up_last(in_beat.last), .up_ready(in_ready),
    .dn_valid(pk_valid), .dn_ready_early(pk_ready_early),
    .lane_last(1'b0), .at_end(pk_at_end),
    .cnt_load(pk_load), .cnt_step(pk_step), .cnt_clear(pk_clear),
    .capture(pk_capture), .emit()
  );

  lane_counter pk_cnt (
    .clk(clk), .rst(rst), .load(pk_load), .step(pk_step), .clear(pk_clear),
    .load_val(lane_idx_t'(1)), .idx(pk_idx), .at_end(pk_at_end)
  );

  lane_packer packer_i (
    .clk(clk), .rst(rst), .in_beat(in_beat), .capture(pk_capture),
    .idx(pk_idx), .wide(pk_wide)
  );

  skid_buffer #(.width($bits(wide_beat_t))) mid_skid (
    .clk(clk), .rst(rst),
    .in_data(pk_wide), .in_valid(pk_valid), .in_ready(), .in_ready_early(pk_ready_early),
    .out_data(mid_wide), .out_valid(mid_valid), .out_ready(mid_ready)
  );

  adapter_fsm #(.expand(1'b0)) unpack_fsm (
    .clk(clk), .rst(rst),
    .up_valid(mid_valid), .up_last(mid_wide.last), .up_ready(mid_ready),
    .dn_valid(un_valid), .dn_ready_early(un_ready_early),
    .lane_last(un_lane_last), .at_end(un_at_end),
    .cnt_load(un_load), .cnt_step(un_step), .cnt_clear(un_clear),
    .capture(un_capture), .emit()
  );

  lane_counter up_cnt (
    .clk(clk), .rst(rst), .load(un_load), .step(un_step), .clear(un_clear),
    .load_val('0), .idx(un_idx), .at_end(un_at_end)
  );

  lane_unpacker unpacker_i (
    .clk(clk), .rst(rst), .wide(mid_wide), .capture(un_capture),
    .idx(un_idx), .narrow(un_narrow), .lane_last(un_lane_last)
  );

  skid_buffer #(.width($bits(narrow_beat_t))) out_skid (
    .clk(clk), .rst(rst),
    .in_data(un_narrow), .in_valid(un_valid), .in_ready(), .in_ready_early(un_ready_early),
    .out_data(out_beat), .out_valid(out_valid), .out_ready(out_ready)
  );

endmodule

// ==== width_loopback_top.f ====
+incdir+dv
hdl/width_adapt_pkg.sv
hdl/lane_counter.sv
hdl/adapter_fsm.sv
hdl/lane_packer.sv
hdl/lane_unpacker.sv
hdl/skid_buffer.sv
hdl/width_loopback_top.sv
dv/width_loopback_tb.sv
